//--- design/pcm_addr_seq.sv
`timescale 1ns/1ns

module pcm_addr_seq (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              cen_i,

    input  logic              job_vld_i,
    input  pcm_pkg::pcm_job_t job_i,

    input  logic              byte_done_i,
    input  logic              stop_i,

    output logic              req_vld_o,
    output pcm_pkg::pcm_req_t req_o,
    output logic              tag_o
);
    import pcm_pkg::*;

    seq_state_e        state_q;
    logic [BASE_W-1:0] base_q;
    logic [RATE_W-1:0] rate_q;
    logic [OFS_W-1:0]  ofs_q;
    logic [RATE_W:0]   tick_cnt;
    logic              tick_full;
    logic              tick_ok;
    logic              tag_q;
    logic              rd_busy;   // A read is out, possibly from an aborted job

    assign tick_full = tick_cnt > {1'b0, rate_q};
    // The final pulse itself releases the read on the next cycle
    assign tick_ok   = tick_full || (cen_i && tick_cnt == {1'b0, rate_q});

    assign tag_o      = tag_q ^ job_vld_i; // New tag visible in the restart cycle
    assign req_vld_o  = (state_q == SEQ_READ) && !job_vld_i;
    assign req_o.addr = {base_q, ofs_q};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= SEQ_IDLE;
            ofs_q    <= '0;
            tick_cnt <= '0;
            tag_q    <= 1'b0;
            rd_busy  <= 1'b0;
        end else begin
            if (req_vld_o) begin
                rd_busy <= 1'b1;
            end else if (byte_done_i) begin
                rd_busy <= 1'b0;
            end

            if (job_vld_i) begin // Restart, even in the middle of a job
                state_q  <= SEQ_WAIT_TICK;
                tag_q    <= ~tag_q;
                ofs_q    <= '0;
                tick_cnt <= '0;
            end else if (stop_i) begin
                state_q <= SEQ_IDLE;
            end else begin
                case (state_q)
                    SEQ_WAIT_TICK: begin
                        if (cen_i && !tick_full) tick_cnt <= tick_cnt + 1'b1;
                        // Stale read from an old job must finish first
                        if (tick_ok && !rd_busy) state_q <= SEQ_READ;
                    end
                    SEQ_READ: state_q <= SEQ_WAIT_DATA;
                    SEQ_WAIT_DATA: begin
                        if (byte_done_i) begin
                            ofs_q    <= ofs_q + 1'b1;
                            tick_cnt <= '0;
                            state_q  <= SEQ_WAIT_TICK;
                        end
                    end
                    default: state_q <= SEQ_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (job_vld_i) begin
            base_q <= job_i.base;
            rate_q <= job_i.rate;
        end
    end

endmodule

//--- design/pcm_cmd_decode.sv
`timescale 1ns/1ns

module pcm_cmd_decode (
    input  logic              clk,
    input  logic              rst_i,

    input  logic              cmd_vld_i,
    input  pcm_pkg::pcm_cmd_t cmd_i,

    output logic              job_vld_o,
    output pcm_pkg::pcm_job_t job_o
);
    import pcm_pkg::*;

    logic [1:0] bank;
    logic       half;
    pcm_job_t   job_d;

    // Highest set select bit wins
    always_comb begin
        casez (cmd_i.ctrl[4:1])
            4'b1???: bank = 2'd3;
            4'b01??: bank = 2'd2;
            4'b001?: bank = 2'd1;
            default: bank = 2'd0;
        endcase
    end

    assign half = cmd_i.ctrl[0];

    always_comb begin
        job_d.base = {bank, half, cmd_i.page};
        job_d.rate = cmd_i.ctrl[7:5]; // Divider in cen_i pulses minus one
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            job_vld_o <= 1'b0;
        end else begin
            job_vld_o <= cmd_vld_i;
        end
    end

    // Job fields only change with a new command
    always_ff @(posedge clk) begin
        if (cmd_vld_i) begin
            job_o <= job_d;
        end
    end

endmodule

//--- design/pcm_fetch.sv
`timescale 1ns/1ns

module pcm_fetch (
    input  logic                       clk,
    input  logic                       rst_i,

    input  logic                       req_vld_i,
    input  pcm_pkg::pcm_req_t          req_i,
    input  logic                       tag_i,

    // Sample ROM, data-ok style reply
    output logic                       rom_cs_o,
    output logic [pcm_pkg::ROM_AW-1:0] rom_addr_o,
    input  logic [7:0]                 rom_data_i,
    input  logic                       rom_ok_i,

    output logic                       byte_vld_o,
    output pcm_pkg::pcm_byte_t         byte_o,
    output logic                       byte_done_o
);
    import pcm_pkg::*;

    logic [ROM_AW-1:0] addr_q;
    logic              req_tag_q; // Job tag at request time
    logic              got_q;
    logic              ok;
    pcm_byte_t         data_q;

    assign ok = rom_cs_o && rom_ok_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rom_cs_o <= 1'b0;
            got_q    <= 1'b0;
        end else begin
            got_q <= ok;
            if (req_vld_i) begin
                rom_cs_o <= 1'b1;
            end else if (ok) begin
                rom_cs_o <= 1'b0; // Held until the ROM answers
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_vld_i) begin
            addr_q    <= req_i.addr;
            req_tag_q <= tag_i;
        end
        if (ok) begin
            data_q.data <= rom_data_i;
            data_q.last <= (rom_data_i == END_MARK) || (addr_q[OFS_W-1:0] == '1);
        end
    end

    assign rom_addr_o  = addr_q;
    assign byte_o      = data_q;
    assign byte_done_o = got_q; // Releases the sequencer even for a dropped byte
    assign byte_vld_o  = got_q && (req_tag_q == tag_i);

endmodule

//--- design/pcm_pkg.sv
package pcm_pkg;

    // Sample ROM geometry, 128 KB
    localparam int ROM_AW = 17;
    localparam int PAGE_W = 6;
    localparam int OFS_W  = 8;

    // Bank, half and page sit above the offset
    localparam int BASE_W = ROM_AW - OFS_W;
    localparam int RATE_W = 3;

    localparam logic [7:0] END_MARK = 8'hFF; // End of sample

    // Host command
    typedef struct packed {
        logic [7:0]        ctrl; // 7..5 rate, 4..1 bank select, 0 half
        logic [PAGE_W-1:0] page;
    } pcm_cmd_t;

    // Job handed from decode to the sequencer
    typedef struct packed {
        logic [BASE_W-1:0] base; // {bank, half, page}
        logic [RATE_W-1:0] rate;
    } pcm_job_t;

    // One ROM read
    typedef struct packed {
        logic [ROM_AW-1:0] addr;
    } pcm_req_t;

    // Fetched sample byte
    typedef struct packed {
        logic [7:0] data;
        logic       last; // End marker or final offset of the page
    } pcm_byte_t;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WAIT_TICK,
        SEQ_READ,
        SEQ_WAIT_DATA
    } seq_state_e;

endpackage

//--- design/pcm_player.sv
`timescale 1ns/1ns

module pcm_player (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       cen_i,      // Sample clock strobe

    input  logic                       cmd_vld_i,
    input  pcm_pkg::pcm_cmd_t          cmd_i,

    output logic                       rom_cs_o,
    output logic [pcm_pkg::ROM_AW-1:0] rom_addr_o,
    input  logic [7:0]                 rom_data_i,
    input  logic                       rom_ok_i,

    output logic signed [7:0]          snd_o,
    output logic                       snd_vld_o,
    output logic                       done_o
);
    import pcm_pkg::*;

    logic      job_vld;
    pcm_job_t  job;
    logic      req_vld;
    pcm_req_t  req;
    logic      tag;
    logic      byte_vld;
    pcm_byte_t byte_q;
    logic      byte_done;
    logic      stop;

    pcm_cmd_decode u_decode (
        .clk        ( clk        ),
        .rst_i      ( rst_i      ),
        .cmd_vld_i  ( cmd_vld_i  ),
        .cmd_i      ( cmd_i      ),
        .job_vld_o  ( job_vld    ),
        .job_o      ( job        )
    );

    pcm_addr_seq u_seq (
        .clk         ( clk       ),
        .rst_i       ( rst_i     ),
        .cen_i       ( cen_i     ),
        .job_vld_i   ( job_vld   ),
        .job_i       ( job       ),
        .byte_done_i ( byte_done ),
        .stop_i      ( stop      ),
        .req_vld_o   ( req_vld   ),
        .req_o       ( req       ),
        .tag_o       ( tag       )
    );

    pcm_fetch u_fetch (
        .clk         ( clk        ),
        .rst_i       ( rst_i      ),
        .req_vld_i   ( req_vld    ),
        .req_i       ( req        ),
        .tag_i       ( tag        ),
        .rom_cs_o    ( rom_cs_o   ),
        .rom_addr_o  ( rom_addr_o ),
        .rom_data_i  ( rom_data_i ),
        .rom_ok_i    ( rom_ok_i   ),
        .byte_vld_o  ( byte_vld   ),
        .byte_o      ( byte_q     ),
        .byte_done_o ( byte_done  )
    );

    pcm_sample_out u_out (
        .clk        ( clk       ),
        .rst_i      ( rst_i     ),
        .byte_vld_i ( byte_vld  ),
        .byte_i     ( byte_q    ),
        .snd_o      ( snd_o     ),
        .snd_vld_o  ( snd_vld_o ),
        .done_o     ( done_o    ),
        .stop_o     ( stop      )
    );

endmodule

//--- design/pcm_sample_out.sv
`timescale 1ns/1ns

module pcm_sample_out (
    input  logic               clk,
    input  logic               rst_i,

    input  logic               byte_vld_i,
    input  pcm_pkg::pcm_byte_t byte_i,

    output logic signed [7:0]  snd_o,
    output logic               snd_vld_o,
    output logic               done_o,
    output logic               stop_o
);
    import pcm_pkg::*;

    logic is_mark;

    assign is_mark = byte_i.data == END_MARK;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            snd_o     <= '0;
            snd_vld_o <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            snd_vld_o <= 1'b0;
            done_o    <= 1'b0;
            if (byte_vld_i) begin
                done_o <= byte_i.last;
                // End marker ends the job without a sample
                if (!(byte_i.last && is_mark)) begin
                    snd_o     <= {~byte_i.data[7], byte_i.data[6:0]}; // Minus 128
                    snd_vld_o <= 1'b1;
                end
            end
        end
    end

    // Level holds between samples
    assign stop_o = done_o;

endmodule

//--- tb.f
design/pcm_pkg.sv
design/pcm_cmd_decode.sv
design/pcm_addr_seq.sv
design/pcm_fetch.sv
design/pcm_sample_out.sv
design/pcm_player.sv
test/pcm_player_props.sv
test/pcm_player_checker.sv
test/pcm_player_tb.sv

//--- test/pcm_cases.txt
# ctrl(hex) page(hex) marker offset(dec, 256 = none) samples before restart(dec, 0 = none)
# ctrl bits 7..5 rate, 4..1 bank select, 0 half
1E 05 32 0
0D 3F 18 0
05 00 64 0
20 11 10 0
E3 2A 5 0
1F 07 256 0
06 3E 256 0
48 20 100 7
1A 21 30 0
9C 15 0 0
0A 30 200 3
62 30 50 0
1E 02 255 0
C0 01 40 0

//--- test/pcm_player_checker.sv
`timescale 1ns/1ns

module pcm_player_checker (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       cmd_vld_i,
    input  pcm_pkg::pcm_cmd_t          cmd_i,
    input  logic [8:0]                 mark_i,     // End marker offset, 256 for none
    input  logic [8:0]                 cut_i,      // Samples before restart, 0 for none
    input  logic                       rom_cs_i,
    input  logic [pcm_pkg::ROM_AW-1:0] rom_addr_i,
    input  logic signed [7:0]          snd_i,
    input  logic                       snd_vld_i,
    input  logic                       done_i,
    output int                         case_cnt_o,
    output int                         pass_cnt_o,
    output int                         err_cnt_o
);
    import pcm_pkg::*;

    logic              active;
    logic              cs_q;
    logic [7:0]        ctrl;
    logic [PAGE_W-1:0] page;
    int                mark;
    int                cut;
    int                smp_idx;
    int                rd_idx;
    int                case_err;
    int                since_cmd;
    int                cyc;
    int                last_rise;

    initial begin
        case_cnt_o = 0;
        pass_cnt_o = 0;
        err_cnt_o  = 0;
    end

    // Highest of ctrl bits 4..1 picks the bank
    function automatic logic [1:0] bank_of(input logic [7:0] c);
        if (c[4]) return 2'd3;
        if (c[3]) return 2'd2;
        if (c[2]) return 2'd1;
        return 2'd0;
    endfunction

    function automatic logic [ROM_AW-1:0] addr_of(input int ofs);
        logic [7:0] o;
        o = ofs[7:0];
        return {bank_of(ctrl), ctrl[0], page, o};
    endfunction

    // Offset XOR five times the 9-bit ROM page, never the marker value
    function automatic logic [7:0] rule_byte(input logic [ROM_AW-1:0] a);
        logic [11:0] prod;
        logic [7:0]  b;
        prod = a[ROM_AW-1:8] * 12'd5;
        b    = a[7:0] ^ prod[7:0];
        return (b == END_MARK) ? 8'hFE : b;
    endfunction

    task automatic value_error(input string msg);
        $display("Fail %0t ns: %s", $time, msg);
        case_err++;
        err_cnt_o++;
    endtask

    task automatic event_error(input string msg);
        $display("At %0t ns: %s", $time, msg);
        err_cnt_o++;
    endtask

    task automatic close_case(input bit restarted);
        case_cnt_o++;
        if (case_err == 0) pass_cnt_o++;
        $display("Case %0d ctrl %h page %h: %0d samples%s, %s", case_cnt_o, ctrl, page,
                 smp_idx, restarted ? " then restart" : "", (case_err == 0) ? "ok" : "mismatch");
        active = 1'b0;
    endtask

    task automatic check_read();
        if (!active) begin
            event_error("ROM read while no case is playing");
        end else if (since_cmd > 2) begin // Earlier rises belong to the old job
            if (rom_addr_i !== addr_of(rd_idx))
                value_error($sformatf("read %0d address %h, expected %h",
                                      rd_idx, rom_addr_i, addr_of(rd_idx)));
            if (rd_idx > 0 && cyc - last_rise < (int'(ctrl[7:5]) + 1) * 3)
                value_error($sformatf("reads %0d cycles apart at rate %0d",
                                      cyc - last_rise, ctrl[7:5]));
            last_rise = cyc;
            rd_idx++;
        end
    endtask

    task automatic check_sample();
        logic [7:0] exp;
        exp = rule_byte(addr_of(smp_idx)) ^ 8'h80;
        if (!active) begin
            event_error("sample strobe while no case is playing");
        end else begin
            if (smp_idx >= ((mark > 255) ? 256 : mark))
                value_error($sformatf("extra sample %0d, value %h", smp_idx, snd_i));
            else if (snd_i !== exp)
                value_error($sformatf("sample %0d is %h, expected %h", smp_idx, snd_i, exp));
            smp_idx++;
        end
    endtask

    task automatic check_done();
        if (!active) begin
            event_error("done strobe while no case is playing");
        end else begin
            if (smp_idx != ((mark > 255) ? 256 : mark))
                value_error($sformatf("done after %0d samples, expected %0d", smp_idx,
                                      (mark > 255) ? 256 : mark));
            if (mark > 255 && !snd_vld_i)
                value_error("done without the final sample beside it");
            close_case(1'b0);
        end
    endtask

    task automatic start_case();
        if (active) begin
            if (smp_idx != cut)
                value_error($sformatf("%0d samples before restart, expected %0d", smp_idx, cut));
            close_case(1'b1);
        end
        ctrl      = cmd_i.ctrl;
        page      = cmd_i.page;
        mark      = mark_i;
        cut       = cut_i;
        smp_idx   = 0;
        rd_idx    = 0;
        case_err  = 0;
        since_cmd = 0;
        active    = 1'b1;
    endtask

    // Old job events in the command cycle are handled before the switch
    always @(posedge clk) begin
        if (rst_i) begin
            active    = 1'b0;
            cs_q      = 1'b0;
            since_cmd = 100;
            cyc       = 0;
        end else begin
            cyc++;
            if (since_cmd < 100) since_cmd++;
            if (rom_cs_i && !cs_q) check_read();
            if (snd_vld_i) check_sample();
            if (done_i) check_done();
            if (cmd_vld_i) start_case();
            cs_q = rom_cs_i;
        end
    end

endmodule

//--- test/pcm_player_props.sv
`timescale 1ns/1ns

module pcm_player_props (
    input logic              clk,
    input logic              rst_i,
    input logic              rom_cs_i,
    input logic              rom_ok_i,
    input logic              snd_vld_i,
    input logic              done_i,
    input logic              job_vld_i,
    input pcm_pkg::pcm_job_t job_i
);
    import pcm_pkg::*;

    logic [RATE_W-1:0] rate_q;
    logic              cs_q;
    logic              armed;      // A read of the current job was seen
    logic [5:0]        gap;        // Cycles since the last chip select rise
    logic              cs_rise;
    int                assert_fails = 0;

    assign cs_rise = rom_cs_i && !cs_q;

    always @(posedge clk) begin
        if (rst_i) begin
            cs_q   <= 1'b0;
            armed  <= 1'b0;
            gap    <= '0;
            rate_q <= '0;
        end else begin
            cs_q <= rom_cs_i;
            if (gap != '1) gap <= gap + 1'b1;
            if (cs_rise) begin
                gap   <= 6'd1;
                armed <= 1'b1;
            end
            // First read of a new job has no spacing rule
            if (job_vld_i) begin
                armed  <= 1'b0;
                rate_q <= job_i.rate;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_i)
        (cs_rise && armed) |-> int'(gap) >= (int'(rate_q) + 1) * 3)
    else begin
        $error("ROM reads closer together than the rate divider allows");
        assert_fails++;
    end

    assert property (@(posedge clk) disable iff (rst_i)
        (rom_cs_i && !rom_ok_i) |=> rom_cs_i)
    else begin
        $error("rom_cs_o dropped before rom_ok_i");
        assert_fails++;
    end

    assert property (@(posedge clk) $fell(rst_i) |-> (!snd_vld_i && !done_i) [*2])
    else begin
        $error("Output strobe right after reset");
        assert_fails++;
    end

endmodule

//--- test/pcm_player_tb.sv
`timescale 1ns/1ns

module pcm_player_tb;
    import pcm_pkg::*;

    logic              clk        = 1'b0;
    logic              rst_i      = 1'b1;
    logic              cen_i      = 1'b0;
    logic              cmd_vld_i  = 1'b0;
    pcm_cmd_t          cmd_i      = '0;
    logic [7:0]        rom_data_i = '0;
    logic              rom_ok_i   = 1'b0;
    logic              rom_cs_o;
    logic [ROM_AW-1:0] rom_addr_o;
    logic signed [7:0] snd_o;
    logic              snd_vld_o;
    logic              done_o;

    logic [7:0]        case_ctrl [$];
    logic [PAGE_W-1:0] case_page [$];
    int                case_mark [$];
    int                case_cut  [$];
    int                n_cases    = 0;
    int                run_cycles = 0;
    logic [8:0]        mark_q     = 9'd256;
    logic [8:0]        cut_q      = '0;
    logic [1:0]        cen_div    = '0;
    integer            seed       = 32'hc53b_7394;
    logic              rom_busy   = 1'b0;
    int                rom_wait   = 0;
    logic [ROM_AW-1:0] rom_lat    = '0;
    int                case_cnt;
    int                pass_cnt;
    int                err_cnt;

    always #2 clk = ~clk;

    pcm_player DUT (
        .clk        ( clk        ),
        .rst_i      ( rst_i      ),
        .cen_i      ( cen_i      ),
        .cmd_vld_i  ( cmd_vld_i  ),
        .cmd_i      ( cmd_i      ),
        .rom_cs_o   ( rom_cs_o   ),
        .rom_addr_o ( rom_addr_o ),
        .rom_data_i ( rom_data_i ),
        .rom_ok_i   ( rom_ok_i   ),
        .snd_o      ( snd_o      ),
        .snd_vld_o  ( snd_vld_o  ),
        .done_o     ( done_o     )
    );

    pcm_player_checker u_check (
        .clk        ( clk        ),
        .rst_i      ( rst_i      ),
        .cmd_vld_i  ( cmd_vld_i  ),
        .cmd_i      ( cmd_i      ),
        .mark_i     ( mark_q     ),
        .cut_i      ( cut_q      ),
        .rom_cs_i   ( rom_cs_o   ),
        .rom_addr_i ( rom_addr_o ),
        .snd_i      ( snd_o      ),
        .snd_vld_i  ( snd_vld_o  ),
        .done_i     ( done_o     ),
        .case_cnt_o ( case_cnt   ),
        .pass_cnt_o ( pass_cnt   ),
        .err_cnt_o  ( err_cnt    )
    );

    bind pcm_player pcm_player_props u_props (
        .clk(clk), .rst_i(rst_i), .rom_cs_i(rom_cs_o), .rom_ok_i(rom_ok_i),
        .snd_vld_i(snd_vld_o), .done_i(done_o), .job_vld_i(job_vld), .job_i(job)
    );

    always @(posedge clk) begin
        cen_div <= (cen_div == 2'd2) ? 2'd0 : cen_div + 2'd1;
        cen_i   <= (cen_div == 2'd2); // Every third clock
    end

    function automatic logic [7:0] rom_byte(input logic [ROM_AW-1:0] a);
        logic [11:0] prod;
        logic [7:0]  b;
        prod = a[ROM_AW-1:8] * 12'd5;
        b    = a[7:0] ^ prod[7:0];
        return (b == END_MARK) ? 8'hFE : b;
    endfunction

    // Answers one read at a time after 1 to 4 cycles
    always @(posedge clk) begin
        rom_ok_i <= 1'b0;
        if (rst_i) begin
            rom_busy <= 1'b0;
        end else if (rom_busy) begin
            if (rom_wait == 1) begin
                rom_ok_i   <= 1'b1;
                rom_busy   <= 1'b0;
                rom_data_i <= (!mark_q[8] &&
                               rom_lat[PAGE_W+OFS_W-1:0] == {cmd_i.page, mark_q[7:0]}) ?
                              END_MARK : rom_byte(rom_lat);
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end else if (rom_cs_o && !rom_ok_i) begin
            rom_busy <= 1'b1;
            rom_lat  <= rom_addr_o;
            rom_wait <= 1 + ($unsigned($random(seed)) % 4);
        end
    end

    task automatic read_cases();
        int         fd;
        int         r;
        string      line;
        logic [7:0] c;
        logic [7:0] p;
        int         m;
        int         k;
        fd = $fopen("test/pcm_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/pcm_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            r = $fgets(line, fd);
            if (r == 0) break;
            if (line.len() < 4 || line[0] == "#") continue;
            if ($sscanf(line, "%h %h %d %d", c, p, m, k) == 4) begin
                case_ctrl.push_back(c);
                case_page.push_back(p[PAGE_W-1:0]);
                case_mark.push_back(m);
                case_cut.push_back(k);
                n_cases++;
            end
        end
        $fclose(fd);
    endtask

    task automatic start_case(input int k);
        @(posedge clk);
        cmd_vld_i  <= 1'b1;
        cmd_i.ctrl <= case_ctrl[k];
        cmd_i.page <= case_page[k];
        mark_q     <= case_mark[k][8:0];
        cut_q      <= case_cut[k][8:0];
        @(posedge clk);
        cmd_vld_i  <= 1'b0;
    endtask

    task automatic wait_for_samples(input int n);
        int cnt;
        cnt = 0;
        while (cnt < n) begin
            @(posedge clk);
            if (snd_vld_o) cnt++;
        end
    endtask

    task automatic wait_for_done();
        do @(posedge clk); while (!done_o);
    endtask

    // Worst case per sample is far below 8 x 3 x 8 cycles
    initial begin
        wait (run_cycles > 0);
        repeat (run_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the player stopped responding", run_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        int total;
        read_cases();
        run_cycles = n_cases * 256 * 8 * 3 * 8;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        for (int k = 0; k < n_cases; k++) begin
            start_case(k);
            if (case_cut[k] > 0) wait_for_samples(case_cut[k]);
            else wait_for_done();
        end
        repeat (20) @(posedge clk);
        total = err_cnt + DUT.u_props.assert_fails;
        if (n_cases == 0 || case_cnt != n_cases) begin
            $display("Only %0d of %0d cases came to an end", case_cnt, n_cases);
            total++;
        end
        $display("%0d of %0d cases passed, %0d errors", pass_cnt, case_cnt, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
